//--- project.f
+incdir+bench
verilog/ethRxPkg.sv
verilog/rxFrameIf.sv
verilog/rxFrameParser.sv
verilog/rxCrcCheck.sv
verilog/ipv4HeaderCheck.sv
verilog/rxDelayLine.sv
verilog/rxStats.sv
verilog/ethRxPort.sv
bench/tbEthRx.sv

//--- run.sh
#!/bin/sh
# Verilator build and run, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tbEthRx -o simv &&
  ./obj_dir/simv > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; echo "Build or simulation aborted"; exit 1; }
cat sim.log
! grep -q "Verification failed" sim.log && echo "Run ok" ||
  { echo "Run reported errors"; exit 1; }

//--- bench/frameGen.svh
// ==============================
// Frame model and builder
// ==============================

logic [15:0] lfsrState = 16'd65102;  // Fixed seed
logic [7:0]  frameQ [$];             // Wire bytes, preamble through FCS
logic [7:0]  payload [64];
int          payLen;
int          errIdx;                 // Wire index driven with rxErr, -1 for none
logic [47:0] expDest;
logic [47:0] expSrc;
logic        expCrcBad;
logic        expIpErr;
int          expPkt = 0;             // Expected counter values
int          expCrcCnt = 0;
int          expIpCnt = 0;

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// n random bits, one LFSR step per bit
task automatic takeBits(input int n, output logic [31:0] val);
  val = '0;
  for (int i = 0; i < n; i++) begin
    val = {val[30:0], lfsrState[0]};
    lfsrState = lfsrStep(lfsrState);
  end
endtask

// Reflected CRC-32, the usual 802.3 software form
function automatic logic [31:0] crcStep(input logic [31:0] r, input logic [7:0] b);
  logic [31:0] c;
  c = r ^ {24'd0, b};
  for (int i = 0; i < 8; i++)
    c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
  return c;
endfunction

// IPv4 header checksum over payload bytes 0 to 19
function automatic logic [15:0] ipChecksum();
  logic [31:0] sum;
  sum = '0;
  for (int w = 0; w < 10; w++)
    sum = sum + {16'd0, payload[2*w], payload[2*w+1]};
  while (sum[31:16] != 16'd0)
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]}; // End-around carry
  return ~sum[15:0];
endfunction

task automatic buildFrame();
  logic [31:0] r;
  logic [31:0] crc;
  logic [15:0] ck;
  logic        ipv4;
  logic        badCk;
  for (int i = 0; i < 6; i++) begin
    takeBits(8, r);
    expDest = {expDest[39:0], r[7:0]};
    takeBits(8, r);
    expSrc = {expSrc[39:0], r[7:0]};
  end
  takeBits(4, r);
  payLen = 46 + int'(r % 15);        // 46 to 60 bytes
  takeBits(1, r);
  ipv4 = r[0];
  takeBits(2, r);
  expCrcBad = (r[1:0] == 2'd0);      // Roughly one frame in four
  takeBits(2, r);
  badCk = (r[1:0] == 2'd0);
  takeBits(1, r);
  errIdx = r[0] ? 30 : -1;           // Mid payload
  for (int i = 0; i < payLen; i++) begin
    takeBits(8, r);
    payload[i] = r[7:0];
  end
  if (ipv4) begin
    payload[0]  = 8'h45;             // Version 4, five words
    payload[10] = 8'h00;
    payload[11] = 8'h00;
    ck = ipChecksum();
    payload[10] = ck[15:8];
    payload[11] = ck[7:0] ^ (badCk ? 8'h5A : 8'h00);
  end
  expIpErr = ipv4 && badCk;
  frameQ.delete();
  repeat (7) frameQ.push_back(8'h55);
  frameQ.push_back(8'hD5);
  for (int i = 0; i < 6; i++)
    frameQ.push_back(expDest[47-8*i -: 8]);
  for (int i = 0; i < 6; i++)
    frameQ.push_back(expSrc[47-8*i -: 8]);
  frameQ.push_back(ipv4 ? 8'h08 : 8'h88); // Other frames use 0x88B5
  frameQ.push_back(ipv4 ? 8'h00 : 8'hB5);
  for (int i = 0; i < payLen; i++)
    frameQ.push_back(payload[i]);
  crc = 32'hFFFF_FFFF;
  for (int i = 8; i < frameQ.size(); i++)
    crc = crcStep(crc, frameQ[i]);
  crc = ~crc;
  for (int i = 0; i < 4; i++)
    frameQ.push_back(crc[8*i +: 8]); // Low byte first on the wire
  if (expCrcBad)
    frameQ[frameQ.size()-1] = frameQ[frameQ.size()-1] ^ 8'h01;
  expPkt = expPkt + 1;
  if (expCrcBad)
    expCrcCnt = expCrcCnt + 1;
  if (expIpErr)
    expIpCnt = expIpCnt + 1;
endtask

//--- bench/tbEthRx.sv
// ==============================
// Ethernet receive testbench
// ==============================

`timescale 1ns/1ps

module tbEthRx;

  localparam int DelayBytes  = 14;
  localparam int numFrames   = 40;
  localparam int idleCycles  = 12;
  localparam int resetCycles = 16;

  logic              RxClk;
  logic              rstN;
  logic              rxValid;
  ethRxPkg::rxByteT  rxData;
  logic              rxErr;
  logic              dataReady;
  logic              clearErrors;
  ethRxPkg::regAddrT regAddr;
  logic              outValid;
  ethRxPkg::rxByteT  outData;
  ethRxPkg::byteStT  outSt;
  logic              crcError;
  logic              ipv4Error;
  ethRxPkg::macAddrT destMac;
  ethRxPkg::regDataT regData;

  int               errors = 0;
  int               checks = 0;
  int               histCnt = 0;       // Clock edges since reset release
  ethRxPkg::byteStT expTag;            // Tag expected for the byte now driven
  logic [10:0]      hist [DelayBytes]; // {valid, tag, data} per edge

  `include "frameGen.svh"

  ethRxPort #(.DelayBytes(DelayBytes)) UUT (.*);

  initial begin
    RxClk = 1'b0;
    forever #20 RxClk = ~RxClk;
  end

  task automatic expectEq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Combinational readback, settles well before the next edge
  task automatic readReg(input ethRxPkg::regAddrT a, output logic [31:0] d);
    regAddr = a;
    #1;
    d = regData;
  endtask

  // Input history, taken where inputs are stable
  always @(posedge RxClk) begin
    for (int i = DelayBytes - 1; i > 0; i--)
      hist[i] = hist[i-1];
    hist[0] = {rxValid, expTag, rxData};
    if (rstN)
      histCnt = histCnt + 1;
  end

  // Delayed stream against history
  always @(negedge RxClk) begin
    if (histCnt >= DelayBytes) begin
      expectEq("outValid", outValid, hist[DelayBytes-1][10]);
      expectEq("outSt", outSt, hist[DelayBytes-1][9:8]);
      if (outValid)
        expectEq("outData", outData, hist[DelayBytes-1][7:0]);
    end
  end

  task automatic checkFrame();
    logic [31:0] d;
    expectEq("crcError", crcError, expCrcBad);
    expectEq("ipv4Error", ipv4Error, expIpErr);
    expectEq("destMac", destMac, expDest);
    readReg(ethRxPkg::regPktRecv, d);
    expectEq("regPktRecv", d, expPkt);
    readReg(ethRxPkg::regCrcErr, d);
    expectEq("regCrcErr", d, expCrcCnt);
    readReg(ethRxPkg::regIpv4Err, d);
    expectEq("regIpv4Err", d, expIpCnt);
    readReg(ethRxPkg::regSrcMacHi, d);
    expectEq("regSrcMacHi", d, expSrc[47:16]);
  endtask

  task automatic sendFrame();
    buildFrame();
    for (int i = 0; i < frameQ.size(); i++) begin
      @(negedge RxClk);
      rxValid = 1'b1;
      rxData  = frameQ[i];
      rxErr   = (i == errIdx);
      if (i == 0)
        expTag = ethRxPkg::stFirst;
      else if (i == frameQ.size() - 1)
        expTag = ethRxPkg::stLast;
      else if (i == errIdx)
        expTag = ethRxPkg::stErr;
      else
        expTag = ethRxPkg::stNone;
    end
    for (int i = 0; i < idleCycles; i++) begin
      @(negedge RxClk);
      rxValid = 1'b0;
      rxData  = 8'h00;
      rxErr   = 1'b0;
      expTag  = ethRxPkg::stNone;
      if (i == 1)
        checkFrame(); // frameEnd edge has passed
    end
  endtask

  initial begin
    logic [31:0] d;
    rstN        = 1'b0;
    rxValid     = 1'b0;
    rxData      = 8'h00;
    rxErr       = 1'b0;
    dataReady   = 1'b1;
    clearErrors = 1'b0;
    regAddr     = ethRxPkg::regPktRecv;
    expTag      = ethRxPkg::stNone;
    repeat (resetCycles) @(negedge RxClk);
    rstN = 1'b1;
    expectEq("outValid", outValid, 0);
    expectEq("crcError", crcError, 0);
    expectEq("ipv4Error", ipv4Error, 0);
    readReg(ethRxPkg::regPktRecv, d);
    expectEq("regPktRecv", d, 0);
    repeat (idleCycles) @(negedge RxClk);
    for (int f = 0; f < numFrames; f++)
      sendFrame();
    @(negedge RxClk);
    clearErrors = 1'b1;
    @(negedge RxClk);
    clearErrors = 1'b0;
    expCrcCnt   = 0;             // Only the CRC count clears
    readReg(ethRxPkg::regCrcErr, d);
    expectEq("regCrcErr", d, expCrcCnt);
    readReg(ethRxPkg::regPktRecv, d);
    expectEq("regPktRecv", d, expPkt);
    readReg(ethRxPkg::regIpv4Err, d);
    expectEq("regIpv4Err", d, expIpCnt);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // Every frame fits in 100 cycles with its gap
  initial begin
    repeat ((numFrames + 2) * 100 + resetCycles) @(posedge RxClk);
    $display("Watchdog expired before the test ended, checks run: %0d, errors: %0d",
             checks, errors);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- verilog/ethRxPort.sv
// =============================
// Ethernet receive port
// =============================

`timescale 1ns/1ps

module ethRxPort #(
  parameter int DelayBytes = 14
) (
  input  logic              RxClk,
  input  logic              rstN,
  input  logic              rxValid,
  input  ethRxPkg::rxByteT  rxData,
  input  logic              rxErr,
  input  logic              dataReady,
  input  logic              clearErrors,
  input  ethRxPkg::regAddrT regAddr,
  output logic              outValid,
  output ethRxPkg::rxByteT  outData,
  output ethRxPkg::byteStT  outSt,
  output logic              crcError,
  output logic              ipv4Error,
  output ethRxPkg::macAddrT destMac,
  output ethRxPkg::regDataT regData
);

  ethRxPkg::macAddrT srcMac;
  logic              isIpv4;
  logic              crcBad;

  rxFrameIf frame ();

  rxFrameParser parser (
    .RxClk(RxClk), .rstN(rstN), .rxValid(rxValid), .rxData(rxData),
    .dataReady(dataReady), .destMac(destMac), .srcMac(srcMac),
    .isIpv4(isIpv4), .frame(frame.source)
  );

  rxCrcCheck crcCheck (
    .RxClk(RxClk), .rstN(rstN), .frame(frame.sink),
    .crcBad(crcBad), .crcError(crcError)
  );

  ipv4HeaderCheck ipv4Check (
    .RxClk(RxClk), .rstN(rstN), .frame(frame.sink),
    .isIpv4(isIpv4), .ipv4Error(ipv4Error)
  );

  // Depth must cover the checker latency
  rxDelayLine #(.DelayBytes(DelayBytes)) delayLine (
    .RxClk(RxClk), .rstN(rstN), .rxValid(rxValid), .rxData(rxData),
    .rxErr(rxErr), .outValid(outValid), .outData(outData), .outSt(outSt)
  );

  rxStats stats (
    .RxClk(RxClk), .rstN(rstN), .frame(frame.sink), .crcBad(crcBad),
    .ipv4Error(ipv4Error), .srcMac(srcMac), .clearErrors(clearErrors),
    .regAddr(regAddr), .regData(regData)
  );

endmodule

//--- verilog/rxStats.sv
// =============================
// Receive statistics
// =============================

`timescale 1ns/1ps

module rxStats (
  input  logic               RxClk,
  input  logic               rstN,
  rxFrameIf.sink             frame,
  input  logic               crcBad,
  input  logic               ipv4Error,
  input  ethRxPkg::macAddrT  srcMac,
  input  logic               clearErrors,
  input  ethRxPkg::regAddrT  regAddr,
  output ethRxPkg::regDataT  regData
);

  ethRxPkg::pktCntT pktRecv;
  ethRxPkg::errCntT crcErrCnt;
  ethRxPkg::errCntT ipv4ErrCnt;
  logic [31:0]      srcMacHi;  // Upper source MAC of last frame

  always_ff @(posedge RxClk) begin
    if (!rstN) begin
      pktRecv    <= '0;
      crcErrCnt  <= '0;
      ipv4ErrCnt <= '0;
      srcMacHi   <= '0;
    end else begin
      if (frame.frameEnd) begin
        pktRecv  <= pktRecv + 16'd1;
        srcMacHi <= srcMac[47:16];
        if (ipv4Error)
          ipv4ErrCnt <= ipv4ErrCnt + 8'd1; // Verdict from index 20
      end
      if (clearErrors)
        crcErrCnt <= '0;   // CRC count only
      else if (crcBad)
        crcErrCnt <= crcErrCnt + 8'd1;
    end
  end

  // Combinational readback
  always_comb begin
    case (regAddr)
      ethRxPkg::regPktRecv:  regData = ethRxPkg::regDataT'(pktRecv);
      ethRxPkg::regCrcErr:   regData = ethRxPkg::regDataT'(crcErrCnt);
      ethRxPkg::regIpv4Err:  regData = ethRxPkg::regDataT'(ipv4ErrCnt);
      default:               regData = srcMacHi;
    endcase
  end

endmodule

//--- verilog/rxDelayLine.sv
// =============================
// Receive delay line
// =============================

`timescale 1ns/1ps

module rxDelayLine #(
  parameter int DelayBytes = 14
) (
  input  logic              RxClk,
  input  logic              rstN,
  input  logic              rxValid,
  input  ethRxPkg::rxByteT  rxData,
  input  logic              rxErr,
  output logic              outValid,
  output ethRxPkg::rxByteT  outData,
  output ethRxPkg::byteStT  outSt
);

  ethRxPkg::rxByteT [DelayBytes-1:0] dataSr;
  logic [DelayBytes:0]               validSr;  // One extra stage for the rising edge
  logic [DelayBytes-1:0]             errSr;
  logic                              isFirst;
  logic                              isLast;

  always_ff @(posedge RxClk) begin
    dataSr <= {dataSr[DelayBytes-2:0], rxData};
  end

  always_ff @(posedge RxClk) begin
    if (!rstN) begin
      validSr <= '0;
      errSr   <= '0;
    end else begin
      validSr <= {validSr[DelayBytes-1:0], rxValid};
      errSr   <= {errSr[DelayBytes-2:0], rxErr};
    end
  end

  assign outValid = validSr[DelayBytes-1];
  assign outData  = dataSr[DelayBytes-1];

  assign isFirst = validSr[DelayBytes-1] && !validSr[DelayBytes];
  assign isLast  = validSr[DelayBytes-1] && !validSr[DelayBytes-2]; // Next byte idle

  always_comb begin
    if (isFirst)
      outSt = ethRxPkg::stFirst;
    else if (isLast)
      outSt = ethRxPkg::stLast;
    else if (errSr[DelayBytes-1])
      outSt = ethRxPkg::stErr;
    else
      outSt = ethRxPkg::stNone;
  end

  // Last byte of a frame is followed by an idle output
  assert property (@(posedge RxClk) disable iff (!rstN)
                   (outSt == ethRxPkg::stLast) |=> !outValid)
    else $error("stLast not followed by idle");

endmodule

//--- verilog/ipv4HeaderCheck.sv
// =============================
// IPv4 header checksum
// =============================

`timescale 1ns/1ps

module ipv4HeaderCheck (
  input  logic   RxClk,
  input  logic   rstN,
  rxFrameIf.sink frame,
  input  logic   isIpv4,
  output logic   ipv4Error
);

  ethRxPkg::cksumT cksum;  // Ones-complement sum with pending carry
  logic            dataAcc;

  assign dataAcc = frame.frameByte && frame.inData;

  always_ff @(posedge RxClk) begin
    if (dataAcc) begin
      if (frame.dataIdx == 5'd0)
        cksum <= {1'b0, frame.dataByte, 8'd0};           // First high byte
      else if (!frame.dataIdx[0])
        cksum <= {1'b0, cksum[15:0]} +
                 {1'b0, frame.dataByte, 7'd0, cksum[16]}; // High byte, fold carry
      else
        cksum <= cksum + {9'd0, frame.dataByte};          // Low byte
    end
  end

  always_ff @(posedge RxClk) begin
    if (!rstN)
      ipv4Error <= 1'b0;
    else if (frame.frameStart)
      ipv4Error <= 1'b0;
    else if (dataAcc && (frame.dataIdx == ethRxPkg::ipv4HdrEndIdx))
      // Last carry is not folded yet, so 0x1FFFE is also good
      ipv4Error <= isIpv4 && (cksum != 17'h0FFFF) && (cksum != 17'h1FFFE);
  end

endmodule

//--- verilog/rxCrcCheck.sv
// =============================
// Receive CRC-32 check
// =============================

`timescale 1ns/1ps

module rxCrcCheck (
  input  logic   RxClk,
  input  logic   rstN,
  rxFrameIf.sink frame,
  output logic   crcBad,   // Verdict while frameEnd is high
  output logic   crcError
);

  localparam ethRxPkg::crcT crcPoly = 32'h04C1_1DB7;

  ethRxPkg::crcT crcReg;

  // One byte, wire order is LSB first
  function automatic ethRxPkg::crcT crcByte(ethRxPkg::crcT crc, ethRxPkg::rxByteT d);
    ethRxPkg::crcT c;
    logic          fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[31] ^ d[i];
      c  = {c[30:0], 1'b0} ^ (fb ? crcPoly : '0);
    end
    return c;
  endfunction

  always_ff @(posedge RxClk) begin
    if (frame.frameStart)
      crcReg <= ethRxPkg::crcInit;
    else if (frame.frameByte)
      crcReg <= crcByte(crcReg, frame.dataByte); // FCS included
  end

  // Residue check once the FCS has gone through
  assign crcBad = frame.frameEnd && (crcReg != ethRxPkg::crcResidue);

  always_ff @(posedge RxClk) begin
    if (!rstN)
      crcError <= 1'b0;
    else if (frame.frameEnd)
      crcError <= crcBad; // Held until the next frame ends
  end

endmodule

//--- verilog/rxFrameParser.sv
// =============================
// Receive frame parser
// =============================

`timescale 1ns/1ps

module rxFrameParser (
  input  logic              RxClk,
  input  logic              rstN,
  input  logic              rxValid,
  input  ethRxPkg::rxByteT  rxData,
  input  logic              dataReady,
  output ethRxPkg::macAddrT destMac,
  output ethRxPkg::macAddrT srcMac,
  output logic              isIpv4,
  rxFrameIf.source          frame
);

  ethRxPkg::rxStateT state;
  logic [4:0]        byteCnt;  // Header offset, then data index
  logic              accept;
  logic              inData;
  ethRxPkg::rxByteT  header [ethRxPkg::headerBytes];

  assign accept = rxValid & dataReady; // Client mask, no back-pressure
  assign inData = (state == ethRxPkg::rxData);

  // Frame events straight from inputs and state
  assign frame.dataByte   = rxData;
  assign frame.frameStart = (state == ethRxPkg::rxIdle) && accept &&
                            (rxData == ethRxPkg::sfdByte);
  assign frame.frameByte  = accept && (state != ethRxPkg::rxIdle);
  assign frame.inData     = inData;
  assign frame.frameEnd   = inData && !rxValid;
  assign frame.dataIdx    = byteCnt;

  // Header bytes land at their offset
  always_ff @(posedge RxClk) begin
    if ((state == ethRxPkg::rxHeader) && accept)
      header[byteCnt[3:0]] <= rxData;
  end

  // MAC fields, first byte is most significant
  always_comb begin
    for (int i = 0; i < 6; i++) begin
      destMac[47-8*i -: 8] = header[ethRxPkg::destMacOfs + i];
      srcMac[47-8*i -: 8]  = header[ethRxPkg::srcMacOfs + i];
    end
  end

  assign isIpv4 = ({header[ethRxPkg::lenTypeOfs], header[ethRxPkg::lenTypeOfs + 1]} ==
                   ethRxPkg::ipv4Type);

  always_ff @(posedge RxClk) begin
    if (!rstN) begin
      state   <= ethRxPkg::rxIdle;
      byteCnt <= '0;
    end else begin
      case (state)
        ethRxPkg::rxIdle: begin
          // Preamble is swallowed until the delimiter
          if (accept && (rxData == ethRxPkg::sfdByte)) begin
            state   <= ethRxPkg::rxHeader;
            byteCnt <= '0;
          end
        end
        ethRxPkg::rxHeader: begin
          if (accept) begin
            byteCnt <= byteCnt + 5'd1;
            if (byteCnt == 5'(ethRxPkg::headerBytes - 1)) begin
              state   <= ethRxPkg::rxData;
              byteCnt <= '0;
            end
          end else if (!rxValid) begin
            state   <= ethRxPkg::rxIdle; // Runt, drop it
            byteCnt <= '0;
          end
        end
        ethRxPkg::rxData: begin
          if (accept) begin
            if (byteCnt != ethRxPkg::dataIdxMax)
              byteCnt <= byteCnt + 5'd1; // Only the IPv4 header needs an index
          end else if (!rxValid) begin
            state   <= ethRxPkg::rxIdle;
            byteCnt <= '0;
          end
        end
        default: state <= ethRxPkg::rxIdle;
      endcase
    end
  end

  // Header offset stays inside the capture buffer
  assert property (@(posedge RxClk) disable iff (!rstN)
                   (state == ethRxPkg::rxHeader) |->
                   (byteCnt < 5'(ethRxPkg::headerBytes)))
    else $error("header offset out of range");

endmodule

//--- verilog/rxFrameIf.sv
// =============================
// Receive frame event bus
// =============================

`timescale 1ns/1ps

interface rxFrameIf;

  ethRxPkg::rxByteT dataByte;   // Current input byte
  logic             frameByte;  // Accepted byte in header or data
  logic             frameStart; // Delimiter accepted
  logic [4:0]       dataIdx;    // Index within data phase, saturates
  logic             inData;     // Parser in data state
  logic             frameEnd;   // First idle cycle after data

  modport source (
    output dataByte, frameByte, frameStart, dataIdx, inData, frameEnd
  );

  modport sink (
    input dataByte, frameByte, frameStart, dataIdx, inData, frameEnd
  );

endinterface

//--- verilog/ethRxPkg.sv
// =============================
// Ethernet receive definitions
// =============================

package ethRxPkg;

  typedef logic [7:0]  rxByteT;   // One byte on the GMII side
  typedef logic [47:0] macAddrT;
  typedef logic [31:0] crcT;
  typedef logic [16:0] cksumT;    // 16-bit sum plus carry
  typedef logic [15:0] pktCntT;
  typedef logic [7:0]  errCntT;
  typedef logic [31:0] regDataT;
  typedef logic [1:0]  regAddrT;
  typedef logic [1:0]  byteStT;   // Per-byte status tag

  typedef enum logic [1:0] {rxIdle, rxHeader, rxData} rxStateT;

  // Byte status codes
  localparam byteStT stNone  = 2'b00;
  localparam byteStT stFirst = 2'b01;
  localparam byteStT stLast  = 2'b10;
  localparam byteStT stErr   = 2'b11;

  localparam rxByteT      sfdByte       = 8'hD5; // Start of frame delimiter
  localparam int          headerBytes   = 14;
  localparam int          destMacOfs    = 0;
  localparam int          srcMacOfs     = 6;
  localparam int          lenTypeOfs    = 12;
  localparam logic [15:0] ipv4Type      = 16'h0800;
  localparam logic [4:0]  ipv4HdrEndIdx = 5'd20;   // First byte after a 20-byte IPv4 header
  localparam crcT         crcInit       = 32'hFFFF_FFFF;
  localparam crcT         crcResidue    = 32'hC704_DD7B; // Good frame incl. FCS
  localparam logic [4:0]  dataIdxMax    = 5'd31;

  // Register map
  localparam regAddrT regPktRecv  = 2'd0;
  localparam regAddrT regCrcErr   = 2'd1;
  localparam regAddrT regIpv4Err  = 2'd2;
  localparam regAddrT regSrcMacHi = 2'd3;

endpackage
